/* router_pkg.sv */
`default_nettype none

package router_pkg;

    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 6;
    localparam int NUM_PORTS = 5;

    // dest splits into group bits above spine bits.
    localparam int SPINE_W = 2;
    localparam int GROUP_W = ADDR_W - SPINE_W;

    // 0 is the gpu, 1..4 the spines.
    typedef logic [2:0] port_idx_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] dest;
    } flit_t;

    typedef enum logic [1:0] {
        DIR_IDLE = 2'b00,
        DIR_DOWN = 2'b01, // to the gpu.
        DIR_UP   = 2'b10  // to a spine.
    } dir_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_GRANT = 2'b01,
        ST_HOLD  = 2'b10
    } arb_state_e;

    // one-cycle command from controller to switch.
    typedef struct packed {
        logic      valid;
        port_idx_t src;
        port_idx_t dst;
    } grant_t;

endpackage

`default_nettype wire

/* port_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module port_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire router_pkg::flit_t in_flit,
    input  wire               in_valid,
    output logic              in_ready,
    output router_pkg::flit_t head,
    output logic              head_valid,
    input  wire               pop,
    output logic              full,
    output logic              empty
);

    import router_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    flit_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             do_pop;

    assign full       = (count == CNT_W'(FIFO_DEPTH));
    assign empty      = (count == '0);
    assign in_ready   = !full;
    assign head       = mem[rd_ptr];
    assign head_valid = !empty;

    assign push   = in_valid && in_ready;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone.
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the controller must only pop a head it saw valid.
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    );

    a_full_empty_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(full && empty)
    );

endmodule

`default_nettype wire

/* crossbar_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module crossbar_ctrl #(
    parameter logic [router_pkg::GROUP_W-1:0] GROUP_ID = 4'd3
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  arb_enable,
    input  wire router_pkg::flit_t               heads [router_pkg::NUM_PORTS],
    input  wire [router_pkg::NUM_PORTS-1:0]      head_valid,
    input  wire [router_pkg::NUM_PORTS-1:0]      out_busy,
    output router_pkg::grant_t                   grant,
    output logic [router_pkg::NUM_PORTS-1:0]     pop,
    output logic                                 busy,
    output router_pkg::port_idx_t                current_grant,
    output router_pkg::dir_e                     direction
);

    import router_pkg::*;

    port_idx_t              route_dst [NUM_PORTS];
    logic [NUM_PORTS-1:0]   eligible;
    logic                   win_found;
    port_idx_t              win_src;
    port_idx_t              rr_ptr;
    logic                   any_valid;
    arb_state_e             state;
    arb_state_e             state_nxt;

    // own group goes down, anything else up to the named spine.
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (heads[i].dest[ADDR_W-1 -: GROUP_W] == GROUP_ID) begin
                route_dst[i] = '0;
            end else begin
                route_dst[i] = port_idx_t'(heads[i].dest[SPINE_W-1:0]) + port_idx_t'(1);
            end
            eligible[i] = arb_enable && head_valid[i] && !out_busy[route_dst[i]];
        end
    end

    // first eligible head at or after the pointer.
    always_comb begin
        int unsigned idx;
        win_found = 1'b0;
        win_src   = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = rr_ptr + k;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (!win_found && eligible[idx]) begin
                win_found = 1'b1;
                win_src   = port_idx_t'(idx);
            end
        end
    end

    always_comb begin
        grant = '0;
        pop   = '0;
        if (win_found) begin
            grant.valid  = 1'b1;
            grant.src    = win_src;
            grant.dst    = route_dst[win_src];
            pop[win_src] = 1'b1;
        end
    end

    assign any_valid = |head_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (win_found) state_nxt = ST_GRANT;
            end
            ST_GRANT, ST_HOLD: begin
                if (win_found) begin
                    state_nxt = ST_GRANT;
                end else if (!any_valid) begin
                    state_nxt = ST_IDLE;
                end else begin
                    state_nxt = ST_HOLD; // heads stuck behind busy outputs.
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            rr_ptr        <= '0;
            current_grant <= '0;
            direction     <= DIR_IDLE;
        end else begin
            state <= state_nxt;
            if (win_found) begin
                rr_ptr        <= (win_src == port_idx_t'(NUM_PORTS - 1)) ? '0 : win_src + 1'b1;
                current_grant <= win_src;
                direction     <= (route_dst[win_src] == '0) ? DIR_DOWN : DIR_UP;
            end else begin
                direction <= DIR_IDLE; // grant index keeps the last winner.
            end
        end
    end

    a_pop_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(pop)
    );

    // the switch must never be asked to overwrite a waiting flit.
    a_grant_free_dst: assert property (
        @(posedge clk) disable iff (!rst_n) grant.valid |-> !out_busy[grant.dst]
    );

endmodule

`default_nettype wire

/* xbar_switch.sv */
`timescale 1ns/1ns
`default_nettype none

module xbar_switch (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire router_pkg::flit_t            heads [router_pkg::NUM_PORTS],
    input  wire router_pkg::grant_t           grant,
    output router_pkg::flit_t                 out_flit [router_pkg::NUM_PORTS],
    output logic [router_pkg::NUM_PORTS-1:0]  out_valid,
    input  wire [router_pkg::NUM_PORTS-1:0]   out_ready,
    output logic [router_pkg::NUM_PORTS-1:0]  out_busy
);

    import router_pkg::*;

    flit_t                sel_flit;
    logic [NUM_PORTS-1:0] load;

    assign sel_flit = heads[grant.src];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            load[p] = grant.valid && (grant.dst == port_idx_t'(p));
        end
    end

    // a register being taken this cycle counts as free.
    assign out_busy = out_valid & ~out_ready;

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (load[p]) begin
                out_flit[p] <= sel_flit;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (load[p]) begin
                    out_valid[p] <= 1'b1;
                end else if (out_ready[p]) begin
                    out_valid[p] <= 1'b0;
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_hold
        // receiver sees the same flit until it takes it.
        a_out_stable: assert property (
            @(posedge clk) disable iff (!rst_n)
            (out_valid[g] && !out_ready[g]) |=> (out_valid[g] && $stable(out_flit[g]))
        );
    end

endmodule

`default_nettype wire

/* enhanced_router.sv */
`timescale 1ns/1ns
`default_nettype none

module enhanced_router #(
    parameter int                              FIFO_DEPTH = 8,
    parameter logic [router_pkg::GROUP_W-1:0]  GROUP_ID   = 4'd3
) (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               arb_enable,

    input  wire router_pkg::flit_t            in_flit [router_pkg::NUM_PORTS],
    input  wire [router_pkg::NUM_PORTS-1:0]   in_valid,
    output wire [router_pkg::NUM_PORTS-1:0]   in_ready,

    output router_pkg::flit_t                 out_flit [router_pkg::NUM_PORTS],
    output wire [router_pkg::NUM_PORTS-1:0]   out_valid,
    input  wire [router_pkg::NUM_PORTS-1:0]   out_ready,

    output wire [router_pkg::NUM_PORTS-1:0]   fifo_full,
    output wire [router_pkg::NUM_PORTS-1:0]   fifo_empty,

    output wire                               crossbar_busy,
    output router_pkg::port_idx_t             current_grant,
    output router_pkg::dir_e                  routing_direction
);

    import router_pkg::*;

    flit_t                heads [NUM_PORTS];
    logic [NUM_PORTS-1:0] head_valid;
    logic [NUM_PORTS-1:0] pop;
    logic [NUM_PORTS-1:0] out_busy;
    grant_t               grant;

    // port 0 is the gpu.
    port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit[0]), .in_valid(in_valid[0]), .in_ready(in_ready[0]),
        .head(heads[0]), .head_valid(head_valid[0]), .pop(pop[0]),
        .full(fifo_full[0]), .empty(fifo_empty[0])
    );

    port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo1 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit[1]), .in_valid(in_valid[1]), .in_ready(in_ready[1]),
        .head(heads[1]), .head_valid(head_valid[1]), .pop(pop[1]),
        .full(fifo_full[1]), .empty(fifo_empty[1])
    );

    port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo2 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit[2]), .in_valid(in_valid[2]), .in_ready(in_ready[2]),
        .head(heads[2]), .head_valid(head_valid[2]), .pop(pop[2]),
        .full(fifo_full[2]), .empty(fifo_empty[2])
    );

    port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo3 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit[3]), .in_valid(in_valid[3]), .in_ready(in_ready[3]),
        .head(heads[3]), .head_valid(head_valid[3]), .pop(pop[3]),
        .full(fifo_full[3]), .empty(fifo_empty[3])
    );

    port_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo4 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit[4]), .in_valid(in_valid[4]), .in_ready(in_ready[4]),
        .head(heads[4]), .head_valid(head_valid[4]), .pop(pop[4]),
        .full(fifo_full[4]), .empty(fifo_empty[4])
    );

    crossbar_ctrl #(
        .GROUP_ID(GROUP_ID)
    ) ctrl0 (
        .clk(clk),
        .rst_n(rst_n),
        .arb_enable(arb_enable),
        .heads(heads),
        .head_valid(head_valid),
        .out_busy(out_busy),
        .grant(grant),
        .pop(pop),
        .busy(crossbar_busy),
        .current_grant(current_grant),
        .direction(routing_direction)
    );

    // one flit per cycle into the output registers.
    xbar_switch switch0 (
        .clk(clk),
        .rst_n(rst_n),
        .heads(heads),
        .grant(grant),
        .out_flit(out_flit),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_busy(out_busy)
    );

endmodule

`default_nettype wire

/* router_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module router_tb;

    import router_pkg::*;

    localparam int          CLK_PERIOD      = 40;
    localparam int          RST_CYCLES      = 16;
    localparam int          FIFO_DEPTH      = 8;
    localparam logic [3:0]  GROUP_ID        = 4'd3;
    localparam logic [31:0] SEED            = 32'hb0e98531;
    localparam int          N_ROUTE         = 20;
    localparam int          N_ORDER         = 30;
    localparam int          N_BP            = 40;
    localparam int          CYCLES_PER_FLIT = 4;
    localparam int          TOTAL_FLITS     = NUM_PORTS * (N_ROUTE + N_ORDER + N_BP + FIFO_DEPTH);
    localparam int          TEST_CYCLES     = RST_CYCLES + TOTAL_FLITS * CYCLES_PER_FLIT;

    logic                 clk;
    logic                 rst_n;
    logic                 arb_enable;
    flit_t                in_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    flit_t                out_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready;
    logic [NUM_PORTS-1:0] fifo_full;
    logic [NUM_PORTS-1:0] fifo_empty;
    logic                 crossbar_busy;
    port_idx_t            current_grant;
    dir_e                 routing_direction;

    // reference model state, one queue per source and destination pair.
    flit_t                exp_q [NUM_PORTS*NUM_PORTS][$];
    logic [12:0]          seq [NUM_PORTS];
    logic [NUM_PORTS-1:0] taken = '0;
    logic [NUM_PORTS-1:0] prev_busy = '0;
    int                   outstanding = 0;
    logic                 dir_seen = 1'b0;
    logic                 full_seen = 1'b0;
    logic                 gate_closed = 1'b0;
    string                cur_test = "reset";

    enhanced_router #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .GROUP_ID(GROUP_ID)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .arb_enable(arb_enable),
        .in_flit(in_flit),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_flit(out_flit),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .fifo_full(fifo_full),
        .fifo_empty(fifo_empty),
        .crossbar_busy(crossbar_busy),
        .current_grant(current_grant),
        .routing_direction(routing_direction)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_flit(input string name, input flit_t exp, input flit_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected data=%h dest=%h, actual data=%h dest=%h",
                                name, exp.data, exp.dest, act.data, act.dest));
        end
    endtask

    task automatic check_dir(input string name, input dir_e exp, input dir_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected direction %s, actual %s",
                                name, exp.name(), act.name()));
        end
    endtask

    task automatic check_port(input string name, input port_idx_t exp, input port_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected port %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input logic [NUM_PORTS-1:0] exp,
                              input logic [NUM_PORTS-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // own group goes to the gpu, else to spine (low bits + 1).
    function automatic port_idx_t route_of(input logic [ADDR_W-1:0] dest);
        if (dest[5:2] == GROUP_ID) begin
            return 3'd0;
        end
        return {1'b0, dest[1:0]} + 3'd1;
    endfunction

    // payload carries the source port above a sequence number.
    function automatic flit_t new_flit(input int src);
        flit_t f;
        f.data   = {3'(src), seq[src]};
        seq[src] = seq[src] + 1'b1;
        if ($urandom % 2) begin
            f.dest = {GROUP_ID, 2'($urandom)};
        end else begin
            f.dest = 6'($urandom);
        end
        return f;
    endfunction

    always @(posedge clk) begin : monitor
        logic [NUM_PORTS-1:0] new_load;
        port_idx_t            tag_src;
        int                   src;
        int                   q;
        if (rst_n) begin
            if (routing_direction != DIR_IDLE) dir_seen = 1'b1;
            if (gate_closed && (out_valid != '0)) begin
                abort_run("an output became valid while arbitration was disabled");
            end
            new_load = out_valid & ~prev_busy; // register loaded on the last edge.
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (new_load[p]) begin
                    check_dir(cur_test, (p == 0) ? DIR_DOWN : DIR_UP, routing_direction);
                    tag_src = out_flit[p].data[DATA_W-1 -: 3]; // winner is the tagged source.
                    check_port({cur_test, " current_grant"}, tag_src, current_grant);
                end
            end
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (in_valid[i] && in_ready[i]) begin
                    exp_q[i*NUM_PORTS + route_of(in_flit[i].dest)].push_back(in_flit[i]);
                    taken[i]    = 1'b1;
                    outstanding = outstanding + 1;
                end
                if (fifo_full[i] && !in_ready[i]) full_seen = 1'b1;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    if (!dir_seen) begin
                        abort_run("a flit left before any routing direction was shown");
                    end
                    src = out_flit[p].data[DATA_W-1 -: 3];
                    if (src >= NUM_PORTS) abort_run("an output flit carries an unknown source tag");
                    q = src * NUM_PORTS + p;
                    if (exp_q[q].size() == 0) begin
                        abort_run($sformatf("port %0d delivered an unexpected flit from port %0d",
                                            p, src));
                    end
                    check_flit(cur_test, exp_q[q].pop_front(), out_flit[p]);
                    outstanding = outstanding - 1;
                end
            end
            prev_busy = out_valid & ~out_ready;
        end
    end

    task automatic run_traffic(input int n, input int in_pct, input int rdy_pct);
        int   left [NUM_PORTS];
        logic pending;
        for (int i = 0; i < NUM_PORTS; i++) left[i] = n;
        pending = 1'b1;
        while (pending) begin
            @(negedge clk);
            pending = 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (in_valid[i] && !taken[i]) begin
                    pending = 1'b1; // hold until accepted.
                end else begin
                    taken[i]    = 1'b0;
                    in_valid[i] = 1'b0;
                    if (left[i] > 0) begin
                        pending = 1'b1;
                        if (($urandom % 100) < in_pct) begin
                            in_flit[i]  = new_flit(i);
                            in_valid[i] = 1'b1;
                            left[i]     = left[i] - 1;
                        end
                    end
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) out_ready[p] = (($urandom % 100) < rdy_pct);
        end
    endtask

    task automatic drain_all();
        @(negedge clk);
        out_ready = '1;
        while (outstanding != 0) @(negedge clk);
        @(negedge clk);
        check_mask({cur_test, " fifo_empty"}, '1, fifo_empty);
        check_bit({cur_test, " crossbar_busy"}, 1'b0, crossbar_busy);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        arb_enable = 1'b1;
        in_valid   = '0;
        out_ready  = '1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_flit[i] = '0;
            seq[i]     = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_mask("reset fifo_empty", '1, fifo_empty);
        check_mask("reset in_ready", '1, in_ready);

        cur_test = "routing";
        run_traffic(N_ROUTE, 50, 100);
        drain_all();

        cur_test = "ordering";
        run_traffic(N_ORDER, 100, 100);
        drain_all();

        cur_test = "backpressure";
        run_traffic(N_BP, 100, 25);
        if (!full_seen) abort_run("no ingress FIFO filled up under back-pressure");
        drain_all();

        cur_test    = "arb_gate";
        arb_enable  = 1'b0;
        gate_closed = 1'b1;
        run_traffic(FIFO_DEPTH, 100, 100);
        check_mask("arb_gate fifo_full", '1, fifo_full);
        arb_enable  = 1'b1;
        gate_closed = 1'b0;
        drain_all();

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        abort_run("watchdog: the tests did not finish in the allowed time");
    end

endmodule

`default_nettype wire

/* vlog.f */
router_pkg.sv
port_fifo.sv
crossbar_ctrl.sv
xbar_switch.sv
enhanced_router.sv
router_tb.sv
